// File: qla_pkg.sv
package qla_pkg;

    // --------------------------------------------------
    // bus and data widths
    // --------------------------------------------------
    localparam int ADDR_W   = 16;                 // register address
    localparam int DATA_W   = 32;                 // register data
    localparam int NUM_AXES = 4;                  // motor axes on the QLA
    localparam int SAMPLE_W = 16;                 // adc and dac word
    localparam int AXIS_W   = $clog2(NUM_AXES);   // axis index

    // register address fields
    localparam int SPACE_MSB = 15;
    localparam int SPACE_LSB = 12;
    localparam int CHAN_MSB  = 7;                 // channel 0 is board, 1..4 axes
    localparam int CHAN_LSB  = 4;
    localparam int OFF_MSB   = 3;
    localparam int OFF_LSB   = 0;

    localparam logic [3:0] ADDR_MAIN = 4'd0;      // only space decoded

    // channel 0 offsets
    localparam logic [3:0] REG_STATUS  = 4'd0;
    localparam logic [3:0] REG_VERSION = 4'd1;

    // per-axis offsets
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;   // pot and current
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;   // current command

    localparam logic [DATA_W-1:0] QLA_VERSION = 32'h514C_4131;   // ascii QLA1

    // status word layout
    localparam int STAT_ID_LSB   = 28;            // board id nibble
    localparam int STAT_PWR_BIT  = 19;            // power enable, same bit on write
    localparam int STAT_SAFE_LSB = 8;             // safety disable flags

    // --------------------------------------------------
    // dac serial link
    // --------------------------------------------------
    localparam logic [3:0] DAC_CMD_WRITE  = 4'b0011;   // write and update channel
    localparam int         DAC_FRAME_BITS = 24;        // cmd + axis + data
    localparam int         BIT_CNT_W      = $clog2(DAC_FRAME_BITS);

    // safety check
    localparam logic [SAMPLE_W-1:0] ADC_MIDSCALE  = 16'h8000;   // zero current
    localparam logic [SAMPLE_W-1:0] SAFETY_MARGIN = 16'h0200;
    localparam int                  SAFETY_COUNT  = 4;          // samples to trip
    localparam int                  SAFETY_CNT_W  = $clog2(SAFETY_COUNT + 1);

    // host write strobe with address and data
    typedef struct packed {
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } reg_write_t;

    // parallel adc sample for all axes
    typedef struct packed {
        logic                              ready;
        logic [NUM_AXES-1:0][SAMPLE_W-1:0] cur;
        logic [NUM_AXES-1:0][SAMPLE_W-1:0] pot;
    } adc_sample_t;

    // one axis feedback, also the readback word
    typedef struct packed {
        logic [SAMPLE_W-1:0] pot;
        logic [SAMPLE_W-1:0] cur;
    } axis_fb_t;

    typedef enum logic [2:0] {IDLE, LOAD, SHIFT_LO, SHIFT_HI, DONE} dac_state_e;

endpackage

// File: axis_monitor.sv
`timescale 1ns/100ps

module axis_monitor
    import qla_pkg::*;
(
    input  logic                sysclk,
    input  logic                reset,
    input  logic                ready,           // new adc sample
    input  logic [SAMPLE_W-1:0] cur_in,
    input  logic [SAMPLE_W-1:0] pot_in,
    input  logic [SAMPLE_W-1:0] cur_cmd,         // dac command for this axis
    input  logic                clear_disable,
    output axis_fb_t            fb,
    output logic                safety_disable
);

    logic [SAMPLE_W-1:0]     cur_dev;   // |cur - mid|
    logic [SAMPLE_W-1:0]     cmd_dev;   // |cmd - mid|
    logic [SAMPLE_W-1:0]     cmd_dbl;
    logic [SAMPLE_W:0]       limit;     // one extra bit so the margin never wraps
    logic                    violate;
    logic [SAFETY_CNT_W-1:0] viol_cnt;  // consecutive bad samples

    // --------------------------------------------------
    // deviation compare
    // --------------------------------------------------
    assign cur_dev = (cur_in >= ADC_MIDSCALE) ? cur_in - ADC_MIDSCALE : ADC_MIDSCALE - cur_in;
    assign cmd_dev = (cur_cmd >= ADC_MIDSCALE) ? cur_cmd - ADC_MIDSCALE : ADC_MIDSCALE - cur_cmd;
    assign cmd_dbl = cmd_dev[SAMPLE_W-1] ? {SAMPLE_W{1'b1}}   // saturate
                                         : {cmd_dev[SAMPLE_W-2:0], 1'b0};
    assign limit   = {1'b0, cmd_dbl} + {1'b0, SAFETY_MARGIN};
    assign violate = {1'b0, cur_dev} > limit;

    // feedback latch
    always_ff @(posedge sysclk) begin
        if (reset) begin
            fb <= '{pot: ADC_MIDSCALE, cur: ADC_MIDSCALE};
        end else if (ready) begin
            fb <= '{pot: pot_in, cur: cur_in};
        end
    end

    // sticky trip, clear has priority
    always_ff @(posedge sysclk) begin
        if (reset) begin
            viol_cnt       <= '0;
            safety_disable <= 1'b0;
        end else if (clear_disable) begin
            viol_cnt       <= '0;
            safety_disable <= 1'b0;
        end else if (ready) begin
            if (!violate) begin
                viol_cnt <= '0;                          // good sample restarts count
            end else if (viol_cnt != SAFETY_CNT_W'(SAFETY_COUNT)) begin
                viol_cnt <= viol_cnt + 1'b1;
                if (viol_cnt == SAFETY_CNT_W'(SAFETY_COUNT - 1)) begin
                    safety_disable <= 1'b1;              // nth bad sample in a row
                end
            end
        end
    end

endmodule

// File: dac_ctrl.sv
`timescale 1ns/100ps

module dac_ctrl
    import qla_pkg::*;
(
    input  logic                              sysclk,
    input  logic                              reset,
    input  reg_write_t                        bus_wr,
    output logic [NUM_AXES-1:0][SAMPLE_W-1:0] cur_cmd,
    output logic                              dac_csel,   // active low
    output logic                              dac_sclk,
    output logic                              dac_mosi
);

    logic [3:0]                wr_chan;
    logic                      dac_wr;
    logic [AXIS_W-1:0]         wr_axis;
    logic [NUM_AXES-1:0]       pending;     // axes waiting for a frame
    logic [AXIS_W-1:0]         load_axis;
    dac_state_e                state;
    logic [DAC_FRAME_BITS-1:0] shreg;
    logic [BIT_CNT_W-1:0]      bit_cnt;

    // --------------------------------------------------
    // write decode, channels 1..4 at OFF_DAC_CTRL
    // --------------------------------------------------
    assign wr_chan = bus_wr.addr[CHAN_MSB:CHAN_LSB];
    assign dac_wr  = bus_wr.wen
                  && (bus_wr.addr[SPACE_MSB:SPACE_LSB] == ADDR_MAIN)
                  && (wr_chan != 4'd0) && (wr_chan <= 4'(NUM_AXES))
                  && (bus_wr.addr[OFF_MSB:OFF_LSB] == OFF_DAC_CTRL);
    assign wr_axis = AXIS_W'(wr_chan - 4'd1);     // channel 1 is axis 0

    // lowest pending axis goes out first
    always_comb begin
        load_axis = '0;
        for (int i = NUM_AXES - 1; i >= 0; i--) begin
            if (pending[i]) begin
                load_axis = AXIS_W'(i);
            end
        end
    end

    // command store and pending flags
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_cmd <= {NUM_AXES{ADC_MIDSCALE}};
            pending <= '0;
        end else begin
            if (state == LOAD) begin
                pending[load_axis] <= 1'b0;       // taken into the shifter
            end
            if (dac_wr) begin
                cur_cmd[wr_axis] <= bus_wr.data[SAMPLE_W-1:0];
                pending[wr_axis] <= 1'b1;         // newer write wins over the clear
            end
        end
    end

    // --------------------------------------------------
    // serial frame, sclk = sysclk / 2
    // --------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            state    <= IDLE;
            shreg    <= '0;
            bit_cnt  <= '0;
            dac_csel <= 1'b1;
            dac_sclk <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (|pending) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    shreg    <= {DAC_CMD_WRITE, 4'(load_axis), cur_cmd[load_axis]};
                    bit_cnt  <= '0;
                    dac_csel <= 1'b0;             // first bit valid with csel
                    state    <= SHIFT_LO;
                end
                SHIFT_LO: begin
                    dac_sclk <= 1'b1;             // dac samples here
                    state    <= SHIFT_HI;
                end
                SHIFT_HI: begin
                    dac_sclk <= 1'b0;
                    shreg    <= {shreg[DAC_FRAME_BITS-2:0], 1'b0};   // next bit on falling edge
                    bit_cnt  <= bit_cnt + 1'b1;
                    state    <= (bit_cnt == BIT_CNT_W'(DAC_FRAME_BITS - 1)) ? DONE : SHIFT_LO;
                end
                DONE: begin
                    dac_csel <= 1'b1;             // frame ends
                    state    <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign dac_mosi = shreg[DAC_FRAME_BITS-1];    // msb first, zero when idle

endmodule

// File: board_regs.sv
`timescale 1ns/100ps

module board_regs
    import qla_pkg::*;
(
    input  logic                sysclk,
    input  logic                reset,
    input  reg_write_t          bus_wr,
    input  logic [3:0]          wenid,           // rotary switch
    input  logic [NUM_AXES-1:0] safety_disable,
    output logic [DATA_W-1:0]   status,
    output logic [NUM_AXES-1:0] amp_enable,
    output logic [NUM_AXES-1:0] clear_disable    // one cycle per axis
);

    logic                status_wr;
    logic                pwr_en;      // board power
    logic [NUM_AXES-1:0] amp_en_q;    // requested amp enables
    logic [3:0]          board_id;

    assign board_id = ~wenid;         // switch is active low

    // --------------------------------------------------
    // status write decode
    // --------------------------------------------------
    assign status_wr = bus_wr.wen
                    && (bus_wr.addr[SPACE_MSB:SPACE_LSB] == ADDR_MAIN)
                    && (bus_wr.addr[CHAN_MSB:CHAN_LSB] == 4'd0)
                    && (bus_wr.addr[OFF_MSB:OFF_LSB] == REG_STATUS);

    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwr_en        <= 1'b0;
            amp_en_q      <= '0;
            clear_disable <= '0;
        end else begin
            clear_disable <= '0;                                  // pulse only
            if (status_wr) begin
                pwr_en   <= bus_wr.data[STAT_PWR_BIT];
                amp_en_q <= bus_wr.data[NUM_AXES-1:0];
                // power on clears every axis, else just the enabled ones
                clear_disable <= bus_wr.data[STAT_PWR_BIT] ? {NUM_AXES{1'b1}}
                                                           : bus_wr.data[NUM_AXES-1:0];
            end
        end
    end

    // amp runs only with power and no safety trip
    assign amp_enable = amp_en_q & {NUM_AXES{pwr_en}} & ~safety_disable;

    // status word
    always_comb begin
        status                            = '0;
        status[STAT_ID_LSB +: 4]          = board_id;
        status[STAT_PWR_BIT]              = pwr_en;
        status[STAT_SAFE_LSB +: NUM_AXES] = safety_disable;   // live flags
        status[NUM_AXES-1:0]              = amp_en_q;
    end

endmodule

// File: reg_read_mux.sv
`timescale 1ns/100ps

module reg_read_mux
    import qla_pkg::*;
(
    input  logic [ADDR_W-1:0]                 reg_raddr,
    input  logic [DATA_W-1:0]                 status,
    input  axis_fb_t [NUM_AXES-1:0]           fb,
    input  logic [NUM_AXES-1:0][SAMPLE_W-1:0] cur_cmd,
    output logic [DATA_W-1:0]                 reg_rdata
);

    logic [3:0]        space;
    logic [3:0]        chan;
    logic [3:0]        off;
    logic [AXIS_W-1:0] axis;

    assign space = reg_raddr[SPACE_MSB:SPACE_LSB];
    assign chan  = reg_raddr[CHAN_MSB:CHAN_LSB];
    assign off   = reg_raddr[OFF_MSB:OFF_LSB];
    assign axis  = AXIS_W'(chan - 4'd1);          // channel 1 is axis 0

    // zero for anything not mapped
    always_comb begin
        reg_rdata = '0;
        if (space == ADDR_MAIN) begin
            if (chan == 4'd0) begin               // board registers
                case (off)
                    REG_STATUS:  reg_rdata = status;
                    REG_VERSION: reg_rdata = QLA_VERSION;
                    default:     reg_rdata = '0;
                endcase
            end else if (chan <= 4'(NUM_AXES)) begin
                case (off)
                    OFF_ADC_DATA: reg_rdata = fb[axis];                  // pot : cur
                    OFF_DAC_CTRL: reg_rdata = DATA_W'(cur_cmd[axis]);    // zero extended
                    default:      reg_rdata = '0;
                endcase
            end
        end
    end

endmodule

// File: qla_top.sv
`timescale 1ns/100ps

module qla_top
    import qla_pkg::*;
(
    input  logic                sysclk,
    input  logic                reset,
    input  reg_write_t          bus_wr,       // host write port
    input  logic [ADDR_W-1:0]   reg_raddr,    // host read address
    output logic [DATA_W-1:0]   reg_rdata,
    input  adc_sample_t         adc,          // parallel feedback
    input  logic [3:0]          wenid,
    output logic [NUM_AXES-1:0] amp_enable,
    output logic                dac_csel,
    output logic                dac_sclk,
    output logic                dac_mosi
);

    logic [NUM_AXES-1:0][SAMPLE_W-1:0] cur_cmd;          // dac commands
    axis_fb_t [NUM_AXES-1:0]           fb;               // latched feedback
    logic [NUM_AXES-1:0]               safety_disable;
    logic [NUM_AXES-1:0]               clear_disable;
    logic [DATA_W-1:0]                 status;

    // --------------------------------------------------
    // per-axis feedback and safety
    // --------------------------------------------------
    generate
        for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
            axis_monitor u_mon (
                .sysclk         (sysclk),
                .reset          (reset),
                .ready          (adc.ready),
                .cur_in         (adc.cur[i]),
                .pot_in         (adc.pot[i]),
                .cur_cmd        (cur_cmd[i]),
                .clear_disable  (clear_disable[i]),
                .fb             (fb[i]),
                .safety_disable (safety_disable[i])
            );
        end
    endgenerate

    // dac commands and serial link
    dac_ctrl u_dac (
        .sysclk   (sysclk),
        .reset    (reset),
        .bus_wr   (bus_wr),
        .cur_cmd  (cur_cmd),
        .dac_csel (dac_csel),
        .dac_sclk (dac_sclk),
        .dac_mosi (dac_mosi)
    );

    // channel 0
    board_regs u_chan0 (
        .sysclk         (sysclk),
        .reset          (reset),
        .bus_wr         (bus_wr),
        .wenid          (wenid),
        .safety_disable (safety_disable),
        .status         (status),
        .amp_enable     (amp_enable),
        .clear_disable  (clear_disable)
    );

    reg_read_mux u_rmux (
        .reg_raddr (reg_raddr),
        .status    (status),
        .fb        (fb),
        .cur_cmd   (cur_cmd),
        .reg_rdata (reg_rdata)
    );

endmodule

// File: qla_properties.sv
`timescale 1ns/100ps

module qla_properties
    import qla_pkg::*;
(
    input logic                sysclk,
    input logic                reset,
    input logic                dac_csel,
    input logic                dac_sclk,
    input logic [NUM_AXES-1:0] amp_enable,
    input logic [NUM_AXES-1:0] safety_disable
);

    // --------------------------------------------------
    // dac link
    // --------------------------------------------------
    sclk_idle: assert property (@(posedge sysclk) disable iff (reset) dac_csel |-> !dac_sclk)
        else $error("dac_sclk high while dac_csel is high");

    csel_after_reset: assert property (@(posedge sysclk) reset |=> dac_csel)
        else $error("dac_csel low in the cycle after reset");

    // tripped axis must stay off
    amp_off_on_trip: assert property (@(posedge sysclk) disable iff (reset)
        (amp_enable & safety_disable) == '0)
        else $error("amp_enable high on an axis with safety_disable set");

endmodule

bind qla_top qla_properties u_props (
    .sysclk         (sysclk),
    .reset          (reset),
    .dac_csel       (dac_csel),
    .dac_sclk       (dac_sclk),
    .amp_enable     (amp_enable),
    .safety_disable (safety_disable)
);

// File: qla_tb.sv
`timescale 1ns/100ps

module qla_tb
    import qla_pkg::*;
;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_SMP, OP_AMP} op_e;

    // one table row
    typedef struct packed {
        op_e                               op;
        logic [ADDR_W-1:0]                 addr;
        logic [DATA_W-1:0]                 data;
        logic [DATA_W-1:0]                 exp;
        logic [NUM_AXES-1:0][SAMPLE_W-1:0] cur;
        logic [NUM_AXES-1:0][SAMPLE_W-1:0] pot;
    } entry_t;

    localparam logic [3:0] WENID = 4'b1010;   // switch setting so the id reads 5

    logic                      sysclk;
    logic                      reset;
    reg_write_t                bus_wr;
    logic [ADDR_W-1:0]         reg_raddr;
    logic [DATA_W-1:0]         reg_rdata;
    adc_sample_t               adc;
    logic [3:0]                wenid;
    logic [NUM_AXES-1:0]       amp_enable;
    logic                      dac_csel;
    logic                      dac_sclk;
    logic                      dac_mosi;

    entry_t                    tests[$];
    logic [DAC_FRAME_BITS-1:0] frame_q[$];     // frames still to come
    logic [31:0]               lcg_state = 32'h334d;
    logic                      built = 1'b0;

    // reference model of the register state
    logic [SAMPLE_W-1:0]       m_cmd[NUM_AXES];
    int                        m_cnt[NUM_AXES];
    logic [NUM_AXES-1:0]       m_flag;
    logic [NUM_AXES-1:0]       m_amp;
    logic                      m_pwr;

    // serial decoder state
    logic [DAC_FRAME_BITS-1:0] rx_frame;
    logic [DAC_FRAME_BITS-1:0] rx_exp;
    int                        rx_bits;
    logic                      csel_d;

    qla_top DUT (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // --------------------------------------------------
    // expected values
    // --------------------------------------------------
    function automatic bit over_limit(logic [SAMPLE_W-1:0] cur, logic [SAMPLE_W-1:0] cmd);
        int cur_dist;
        int cmd_dist;
        int lim;
        cur_dist = int'(cur) - int'(ADC_MIDSCALE);
        cmd_dist = int'(cmd) - int'(ADC_MIDSCALE);
        if (cur_dist < 0) cur_dist = -cur_dist;
        if (cmd_dist < 0) cmd_dist = -cmd_dist;
        lim = 2 * cmd_dist;
        if (lim > 32'hFFFF) lim = 32'hFFFF;        // doubling saturates at full scale
        return cur_dist > lim + int'(SAFETY_MARGIN);
    endfunction

    function automatic logic [DATA_W-1:0] status_word();
        return {~WENID, 8'h00, m_pwr, 7'h00, m_flag, 4'h0, m_amp};
    endfunction

    function automatic logic [ADDR_W-1:0] axis_addr(int a, logic [3:0] off);
        return {8'h00, 4'(a + 1), off};            // space 0 and channel a+1
    endfunction

    task automatic add_op(op_e op, logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data,
                          logic [DATA_W-1:0] exp);
        entry_t e;
        e      = '0;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.exp  = exp;
        tests.push_back(e);
    endtask

    task automatic wr_cmd(int a, logic [SAMPLE_W-1:0] val);
        add_op(OP_WR, axis_addr(a, OFF_DAC_CTRL), DATA_W'(val), '0);
        m_cmd[a] = val;
    endtask

    task automatic wr_status(logic [DATA_W-1:0] data);
        logic [NUM_AXES-1:0] clr;
        add_op(OP_WR, 16'h0000, data, '0);
        m_pwr = data[19];
        m_amp = data[3:0];
        clr   = data[19] ? 4'hF : data[3:0];      // power bit clears every axis
        for (int a = 0; a < NUM_AXES; a++) begin
            if (clr[a]) begin
                m_flag[a] = 1'b0;
                m_cnt[a]  = 0;
            end
        end
    endtask

    task automatic check_status();
        add_op(OP_RD, 16'h0000, '0, status_word());
        add_op(OP_AMP, '0, '0, DATA_W'(m_amp & {4{m_pwr}} & ~m_flag));
    endtask

    // bad axes get a current near full scale and the rest stay near midscale
    task automatic add_sample(logic [NUM_AXES-1:0] bad);
        entry_t      e;
        logic [31:0] r;
        e    = '0;
        e.op = OP_SMP;
        for (int a = 0; a < NUM_AXES; a++) begin
            r        = lcg_next();
            e.pot[a] = r[31:16];
            e.cur[a] = bad[a] ? 16'hFFFF - 16'(a)
                              : ADC_MIDSCALE - 16'h0100 + (r[15:0] & 16'h01FF);
            if (!over_limit(e.cur[a], m_cmd[a])) begin
                m_cnt[a] = 0;
            end else if (m_cnt[a] < SAFETY_COUNT) begin
                m_cnt[a]++;
                if (m_cnt[a] == SAFETY_COUNT) m_flag[a] = 1'b1;
            end
        end
        tests.push_back(e);
        for (int a = 0; a < NUM_AXES; a++) begin
            add_op(OP_RD, axis_addr(a, OFF_ADC_DATA), '0, {e.pot[a], e.cur[a]});
        end
    endtask

    // --------------------------------------------------
    // test table
    // --------------------------------------------------
    task automatic build_tests();
        for (int a = 0; a < NUM_AXES; a++) begin
            m_cmd[a] = ADC_MIDSCALE;
            m_cnt[a] = 0;
        end
        m_flag = '0;
        m_amp  = '0;
        m_pwr  = 1'b0;
        check_status();                            // id only after reset
        add_op(OP_RD, 16'h0001, '0, QLA_VERSION);
        wr_cmd(0, 16'h8100);                       // starts the first frame
        wr_cmd(3, 16'h1234);                       // queued while axis 0 shifts out
        wr_cmd(2, 16'h8040);
        wr_cmd(1, 16'h7F00);
        wr_cmd(3, 16'h0000);                       // newest value wins and its limit saturates
        for (int a = 0; a < NUM_AXES; a++) begin
            frame_q.push_back({DAC_CMD_WRITE, 4'(a), m_cmd[a]});   // lowest pending axis first
            add_op(OP_RD, axis_addr(a, OFF_DAC_CTRL), '0, {16'h0000, m_cmd[a]});
        end
        wr_status(32'h0008_000F);
        check_status();
        add_op(OP_RD, 16'h1000, '0, '0);           // unused space
        add_op(OP_RD, 16'h0002, '0, '0);           // unused offset
        add_op(OP_RD, 16'h0050, '0, '0);           // channel 5
        repeat (3) add_sample(4'b0000);
        check_status();
        repeat (3) add_sample(4'b0010);            // one short of a trip
        add_sample(4'b0000);                       // good sample restarts the count
        repeat (3) add_sample(4'b0010);
        check_status();
        repeat (4) add_sample(4'b1110);            // axis 3 stays inside its wide limit
        check_status();
        wr_status(32'h0000_0002);                  // clears axis 1 only with power off
        check_status();
        wr_status(32'h0008_000F);
        check_status();
    endtask

    // dac frame decoder takes each bit in the sclk high phase
    initial begin
        rx_frame = '0;
        rx_bits  = 0;
        csel_d   = 1'b1;
        forever begin
            @(negedge sysclk);
            if (!dac_csel && dac_sclk) begin
                rx_frame = {rx_frame[DAC_FRAME_BITS-2:0], dac_mosi};
                rx_bits++;
            end
            if (dac_csel && !csel_d) begin         // csel rose so the frame is done
                assert (frame_q.size() != 0) else abort_run("DAC frame sent with none expected");
                rx_exp = frame_q.pop_front();
                assert (rx_bits == DAC_FRAME_BITS) else abort_run("DAC frame has wrong length");
                assert (rx_frame === rx_exp) else
                    abort_run($sformatf("Fail dac_mosi frame: got %h, expected %h",
                                        rx_frame, rx_exp));
                rx_bits = 0;
            end
            csel_d = dac_csel;
        end
    end

    // watchdog
    initial begin
        wait (built);
        repeat (tests.size() * 200) @(negedge sysclk);
        abort_run("run timed out before the test table finished");
    end

    initial begin
        reset     = 1'b1;
        bus_wr    = '0;
        reg_raddr = '0;
        adc       = '0;
        wenid     = WENID;
        build_tests();
        built = 1'b1;
        repeat (2) @(negedge sysclk);
        reset = 1'b0;
        foreach (tests[i]) begin
            @(negedge sysclk);
            bus_wr.wen = 1'b0;                     // strobes last one cycle
            adc.ready  = 1'b0;
            case (tests[i].op)
                OP_WR:  bus_wr = '{wen: 1'b1, addr: tests[i].addr, data: tests[i].data};
                OP_SMP: adc = '{ready: 1'b1, cur: tests[i].cur, pot: tests[i].pot};
                OP_RD: begin
                    reg_raddr = tests[i].addr;
                    @(negedge sysclk);
                    assert (reg_rdata === tests[i].exp) else
                        abort_run($sformatf("Fail reg_rdata at %h: got %h, expected %h",
                                            tests[i].addr, reg_rdata, tests[i].exp));
                end
                default: begin
                    @(negedge sysclk);
                    assert (amp_enable === tests[i].exp[3:0]) else
                        abort_run($sformatf("Fail amp_enable: got %h, expected %h",
                                            amp_enable, tests[i].exp[3:0]));
                end
            endcase
        end
        bus_wr.wen = 1'b0;
        adc.ready  = 1'b0;
        while (frame_q.size() != 0) @(negedge sysclk);   // let the last frames drain
        assert (dac_csel === 1'b1) else abort_run("DAC link still busy at end of test");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: files.f
qla_pkg.sv
axis_monitor.sv
dac_ctrl.sv
board_regs.sv
reg_read_mux.sv
qla_top.sv
qla_properties.sv
qla_tb.sv

// File: Bender.yml
package:
  name: qla_regs

sources:
  - qla_pkg.sv
  - axis_monitor.sv
  - dac_ctrl.sv
  - board_regs.sv
  - reg_read_mux.sv
  - qla_top.sv
  - target: simulation
    files:
      - qla_properties.sv
      - qla_tb.sv
